// ==== all.f ====
+incdir+sim
common/ex_pkg.sv
rtl/operand_select.sv
rtl/alu.sv
rtl/branch_unit.sv
mult/mult_stage.sv
mult/mult_pipe.sv
rtl/complete_queue.sv
rtl/ex_stage.sv
sim/tb_ex_stage.sv

// ==== common/ex_pkg.sv ====
////////////////////////////////////////
// shared widths and field codes for the
// execute stage and its testbench
// modules import this package by wildcard
////////////////////////////////////////

package ex_pkg;

	////////////////////////////////////////
	// widths
	////////////////////////////////////////
	localparam int XLEN = 32;

	typedef logic [XLEN-1:0]   word_t;  // data or address word
	typedef logic [2*XLEN-1:0] dword_t; // full product
	typedef logic [5:0]        tag_t;   // physical destination tag
	typedef logic [31:0]       inst_t;  // raw instruction

	localparam tag_t ZERO_TAG = 6'd0; // no destination

	////////////////////////////////////////
	// field codes
	////////////////////////////////////////
	typedef logic [1:0] unit_t;
	localparam unit_t UNIT_ALU    = 2'd0;
	localparam unit_t UNIT_MULT   = 2'd1;
	localparam unit_t UNIT_BRANCH = 2'd2;

	typedef logic [3:0] alu_func_t;
	localparam alu_func_t ALU_ADD  = 4'd0;
	localparam alu_func_t ALU_SUB  = 4'd1;
	localparam alu_func_t ALU_AND  = 4'd2;
	localparam alu_func_t ALU_OR   = 4'd3;
	localparam alu_func_t ALU_XOR  = 4'd4;
	localparam alu_func_t ALU_SLT  = 4'd5;
	localparam alu_func_t ALU_SLTU = 4'd6;
	localparam alu_func_t ALU_SLL  = 4'd7;
	localparam alu_func_t ALU_SRL  = 4'd8;
	localparam alu_func_t ALU_SRA  = 4'd9;

	typedef logic [1:0] mult_func_t;
	localparam mult_func_t MULT_MUL    = 2'd0;
	localparam mult_func_t MULT_MULH   = 2'd1;
	localparam mult_func_t MULT_MULHSU = 2'd2; // rs1 signed, rs2 unsigned
	localparam mult_func_t MULT_MULHU  = 2'd3;

	// operand A source
	typedef logic [1:0] opa_sel_t;
	localparam opa_sel_t OPA_RS1  = 2'd0;
	localparam opa_sel_t OPA_NPC  = 2'd1;
	localparam opa_sel_t OPA_PC   = 2'd2;
	localparam opa_sel_t OPA_ZERO = 2'd3;

	// operand B source
	typedef logic [2:0] opb_sel_t;
	localparam opb_sel_t OPB_RS2   = 3'd0;
	localparam opb_sel_t OPB_I_IMM = 3'd1;
	localparam opb_sel_t OPB_S_IMM = 3'd2;
	localparam opb_sel_t OPB_B_IMM = 3'd3;
	localparam opb_sel_t OPB_U_IMM = 3'd4;
	localparam opb_sel_t OPB_J_IMM = 3'd5;

endpackage

// ==== mult/mult_pipe.sv ====
////////////////////////////////////////
// pipelined shift-and-add multiplier
// for MUL, MULH, MULHSU and MULHU
// accepts one multiply per cycle, done is
// high MULT_STAGES cycles after start
////////////////////////////////////////

`timescale 1ns/10ps

module mult_pipe #(
	parameter int MULT_STAGES = 4
) (
	input  logic               clock,
	input  logic               reset,
	input  logic               flush,
	input  logic               start,
	input  ex_pkg::mult_func_t func,
	input  ex_pkg::word_t      mcand,
	input  ex_pkg::word_t      mplier,
	input  ex_pkg::tag_t       tag_in,
	output logic               done,
	output ex_pkg::word_t      product,
	output ex_pkg::tag_t       tag_out
);
	import ex_pkg::*;

	logic mcand_signed, mplier_signed;

	// index 0 is the chain input, MULT_STAGES the chain output
	logic       stage_valid   [MULT_STAGES+1];
	dword_t     stage_mplier  [MULT_STAGES+1];
	dword_t     stage_mcand   [MULT_STAGES+1];
	dword_t     stage_product [MULT_STAGES+1];
	tag_t       stage_tag     [MULT_STAGES+1];
	mult_func_t stage_func    [MULT_STAGES+1];

	assign mcand_signed  = func != MULT_MULHU;                      // rs1 unsigned only for mulhu
	assign mplier_signed = (func == MULT_MUL) || (func == MULT_MULH);

	assign stage_valid[0]   = start;
	assign stage_mcand[0]   = {{XLEN{mcand_signed & mcand[XLEN-1]}}, mcand};
	assign stage_mplier[0]  = {{XLEN{mplier_signed & mplier[XLEN-1]}}, mplier};
	assign stage_product[0] = '0;
	assign stage_tag[0]     = tag_in;
	assign stage_func[0]    = func;

	////////////////////////////////////////
	// stage chain
	////////////////////////////////////////
	for (genvar i = 0; i < MULT_STAGES; i++) begin : g_stage
		mult_stage #(
			.MULT_STAGES (MULT_STAGES)
		) u_mult_stage (
			.clock       (clock),
			.reset       (reset),
			.flush       (flush),
			.valid_in    (stage_valid[i]),
			.mplier_in   (stage_mplier[i]),
			.mcand_in    (stage_mcand[i]),
			.product_in  (stage_product[i]),
			.tag_in      (stage_tag[i]),
			.func_in     (stage_func[i]),
			.valid_out   (stage_valid[i+1]),
			.mplier_out  (stage_mplier[i+1]),
			.mcand_out   (stage_mcand[i+1]),
			.product_out (stage_product[i+1]),
			.tag_out     (stage_tag[i+1]),
			.func_out    (stage_func[i+1])
		);
	end

	assign done    = stage_valid[MULT_STAGES];
	assign tag_out = stage_tag[MULT_STAGES];

	// low half for mul, high half for the rest
	assign product = (stage_func[MULT_STAGES] == MULT_MUL) ?
		stage_product[MULT_STAGES][XLEN-1:0] : stage_product[MULT_STAGES][2*XLEN-1:XLEN];

endmodule

// ==== mult/mult_stage.sv ====
////////////////////////////////////////
// one partial-product stage of the
// pipelined multiplier
// chained MULT_STAGES deep by mult_pipe
////////////////////////////////////////

`timescale 1ns/10ps

module mult_stage #(
	parameter int MULT_STAGES = 4
) (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 flush,
	input  logic                 valid_in,
	input  ex_pkg::dword_t       mplier_in,
	input  ex_pkg::dword_t       mcand_in,
	input  ex_pkg::dword_t       product_in,
	input  ex_pkg::tag_t         tag_in,
	input  ex_pkg::mult_func_t   func_in,
	output logic                 valid_out,
	output ex_pkg::dword_t       mplier_out,
	output ex_pkg::dword_t       mcand_out,
	output ex_pkg::dword_t       product_out,
	output ex_pkg::tag_t         tag_out,
	output ex_pkg::mult_func_t   func_out
);
	import ex_pkg::*;

	localparam int NUM_BITS = 2 * XLEN / MULT_STAGES; // multiplier bits per stage

	dword_t partial;

	assign partial = dword_t'(mplier_in[NUM_BITS-1:0]) * mcand_in;

	always_ff @(posedge clock) begin
		if (reset || flush) begin
			valid_out <= 1'b0;
		end else begin
			valid_out <= valid_in;
		end
	end

	// payload follows the item down the chain
	always_ff @(posedge clock) begin
		product_out <= product_in + partial;
		mplier_out  <= mplier_in >> NUM_BITS;
		mcand_out   <= mcand_in << NUM_BITS;
		tag_out     <= tag_in;
		func_out    <= func_in;
	end

endmodule

// ==== rtl/alu.sv ====
////////////////////////////////////////
// integer ALU of the execute stage
// ten RV32I operations on opa and opb
// purely combinational
////////////////////////////////////////

`timescale 1ns/10ps

module alu (
	input  ex_pkg::word_t     opa,
	input  ex_pkg::word_t     opb,
	input  ex_pkg::alu_func_t func,
	output ex_pkg::word_t     result
);
	import ex_pkg::*;

	localparam word_t ALU_MARKER = 32'hfacebeec; // unknown func code

	logic       lt_signed;
	logic       lt_unsigned;
	logic [4:0] shamt;

	assign lt_signed   = $signed(opa) < $signed(opb);
	assign lt_unsigned = opa < opb;
	assign shamt       = opb[4:0]; // only the low five bits shift

	always_comb begin
		case (func)
			ALU_ADD:  result = opa + opb;
			ALU_SUB:  result = opa - opb;
			ALU_AND:  result = opa & opb;
			ALU_OR:   result = opa | opb;
			ALU_XOR:  result = opa ^ opb;
			ALU_SLT:  result = {{(XLEN-1){1'b0}}, lt_signed};
			ALU_SLTU: result = {{(XLEN-1){1'b0}}, lt_unsigned};
			ALU_SLL:  result = opa << shamt;
			ALU_SRL:  result = opa >> shamt;
			ALU_SRA:  result = $signed(opa) >>> shamt; // keeps the sign bit
			default:  result = ALU_MARKER;
		endcase
	end

endmodule

// ==== rtl/branch_unit.sv ====
////////////////////////////////////////
// branch condition and target for the
// execute stage, purely combinational
////////////////////////////////////////

`timescale 1ns/10ps

module branch_unit (
	input  ex_pkg::word_t rs1_value,
	input  ex_pkg::word_t rs2_value,
	input  ex_pkg::inst_t inst,
	input  ex_pkg::word_t opa,
	input  ex_pkg::word_t opb,
	input  logic          cond_branch,
	input  logic          uncond_branch,
	output logic          take,
	output ex_pkg::word_t target
);
	logic [2:0] funct3;
	logic       cond;

	assign funct3 = inst[14:12];

	always_comb begin
		case (funct3)
			3'b000:  cond = rs1_value == rs2_value;                  // beq
			3'b001:  cond = rs1_value != rs2_value;                  // bne
			3'b100:  cond = $signed(rs1_value) < $signed(rs2_value);  // blt
			3'b101:  cond = $signed(rs1_value) >= $signed(rs2_value); // bge
			3'b110:  cond = rs1_value < rs2_value;                   // bltu
			3'b111:  cond = rs1_value >= rs2_value;                  // bgeu
			default: cond = 1'b0;
		endcase
	end

	// jumps always go, branches only on a true condition
	assign take   = uncond_branch | (cond_branch & cond);
	assign target = opa + opb;

endmodule

// ==== rtl/complete_queue.sv ====
////////////////////////////////////////
// completion queue of the execute stage
// takes the direct result and the multiply
// result each cycle, drains one per cycle
// and derives issue_ready from occupancy
////////////////////////////////////////

`timescale 1ns/10ps

module complete_queue #(
	parameter int MULT_STAGES = 4,
	parameter int QUEUE_DEPTH = 8
) (
	input  logic          clock,
	input  logic          reset,
	input  logic          flush,
	input  logic          now_valid,
	input  ex_pkg::tag_t  now_tag,
	input  ex_pkg::word_t now_result,
	input  logic          now_take,
	input  ex_pkg::word_t now_target,
	input  logic          mult_done,
	input  ex_pkg::tag_t  mult_tag,
	input  ex_pkg::word_t mult_product,
	output logic          issue_ready,
	output logic          complete_valid,
	output ex_pkg::tag_t  complete_tag,
	output ex_pkg::word_t complete_result,
	output logic          take_branch,
	output ex_pkg::word_t branch_target,
	output logic          reg_wr_en
);
	import ex_pkg::*;

	localparam int PTR_W       = $clog2(QUEUE_DEPTH);
	localparam int CNT_W       = $clog2(QUEUE_DEPTH + 1);
	localparam int READY_LIMIT = QUEUE_DEPTH - MULT_STAGES - 2; // room for every mult in flight

	typedef logic [PTR_W-1:0] ptr_t;
	typedef logic [CNT_W-1:0] cnt_t;

	function automatic ptr_t ptr_next(input ptr_t p);
		return (p == ptr_t'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	// entry storage
	tag_t  tag_q    [QUEUE_DEPTH];
	word_t result_q [QUEUE_DEPTH];
	logic  take_q   [QUEUE_DEPTH];
	word_t target_q [QUEUE_DEPTH];

	ptr_t head, tail;
	cnt_t count;
	ptr_t now_slot;  // mult goes at tail, so now slips one behind it
	ptr_t tail_next;
	logic retire;

	assign now_slot = mult_done ? ptr_next(tail) : tail;
	assign retire   = count != '0;

	always_comb begin
		tail_next = tail;
		if (mult_done) tail_next = ptr_next(tail_next);
		if (now_valid) tail_next = ptr_next(tail_next);
	end

	////////////////////////////////////////
	// pointers and occupancy
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset || flush) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			tail  <= tail_next;
			count <= count + cnt_t'(mult_done) + cnt_t'(now_valid) - cnt_t'(retire);
			if (retire) head <= ptr_next(head);
		end
	end

	always_ff @(posedge clock) begin
		if (mult_done) begin
			tag_q[tail]    <= mult_tag;
			result_q[tail] <= mult_product;
			take_q[tail]   <= 1'b0; // multiplies never redirect
			target_q[tail] <= '0;
		end
		if (now_valid) begin
			tag_q[now_slot]    <= now_tag;
			result_q[now_slot] <= now_result;
			take_q[now_slot]   <= now_take;
			target_q[now_slot] <= now_target;
		end
	end

	////////////////////////////////////////
	// completion port, head entry
	////////////////////////////////////////
	assign complete_valid  = retire;
	assign complete_tag    = tag_q[head];
	assign complete_result = result_q[head];
	assign branch_target   = target_q[head];
	assign take_branch     = complete_valid & take_q[head];
	assign reg_wr_en       = complete_valid && (complete_tag != ZERO_TAG);

	assign issue_ready = count <= cnt_t'(READY_LIMIT);

endmodule

// ==== rtl/ex_stage.sv ====
////////////////////////////////////////
// execute stage top level
// one issue per cycle into ALU, branch
// unit or multiplier, one completion per
// cycle out of the completion queue
////////////////////////////////////////

`timescale 1ns/10ps

module ex_stage #(
	parameter int MULT_STAGES = 4,
	parameter int QUEUE_DEPTH = 8
) (
	input  logic               clock,
	input  logic               reset,
	input  logic               flush,
	// issue port
	input  logic               issue_valid,
	input  ex_pkg::unit_t      unit,
	input  ex_pkg::alu_func_t  alu_func,
	input  ex_pkg::mult_func_t mult_func,
	input  ex_pkg::opa_sel_t   opa_sel,
	input  ex_pkg::opb_sel_t   opb_sel,
	input  ex_pkg::inst_t      inst,
	input  ex_pkg::word_t      pc,
	input  ex_pkg::word_t      npc,
	input  ex_pkg::word_t      rs1_value,
	input  ex_pkg::word_t      rs2_value,
	input  ex_pkg::tag_t       dest_tag,
	input  logic               cond_branch,
	input  logic               uncond_branch,
	output logic               issue_ready,
	// completion port
	output logic               complete_valid,
	output ex_pkg::tag_t       complete_tag,
	output ex_pkg::word_t      complete_result,
	output logic               take_branch,
	output ex_pkg::word_t      branch_target,
	output logic               reg_wr_en
);
	import ex_pkg::*;

	word_t opa, opb, alu_result, br_target;
	logic  br_take;
	logic  accept, now_valid, mult_start;
	word_t now_result, now_target;
	logic  now_take;
	logic  mult_done;
	tag_t  mult_tag;
	word_t mult_product;

	assign accept     = issue_valid && issue_ready && !flush; // flush drops this cycle's issue
	assign now_valid  = accept && ((unit == UNIT_ALU) || (unit == UNIT_BRANCH));
	assign mult_start = accept && (unit == UNIT_MULT);

	operand_select u_operand_select (
		.opa_sel   (opa_sel),
		.opb_sel   (opb_sel),
		.inst      (inst),
		.pc        (pc),
		.npc       (npc),
		.rs1_value (rs1_value),
		.rs2_value (rs2_value),
		.opa       (opa),
		.opb       (opb)
	);

	alu u_alu (
		.opa    (opa),
		.opb    (opb),
		.func   (alu_func),
		.result (alu_result)
	);

	branch_unit u_branch_unit (
		.rs1_value     (rs1_value),
		.rs2_value     (rs2_value),
		.inst          (inst),
		.opa           (opa),
		.opb           (opb),
		.cond_branch   (cond_branch),
		.uncond_branch (uncond_branch),
		.take          (br_take),
		.target        (br_target)
	);

	////////////////////////////////////////
	// direct result, alu or branch
	////////////////////////////////////////
	always_comb begin
		now_result = alu_result;
		now_take   = 1'b0;
		now_target = '0;
		if (unit == UNIT_BRANCH) begin
			now_result = '0;
			now_take   = br_take;
			now_target = br_target;
		end else if (uncond_branch) begin // jal/jalr through the alu
			now_result = npc;
			now_take   = 1'b1;
			now_target = alu_result;
		end
	end

	mult_pipe #(
		.MULT_STAGES (MULT_STAGES)
	) u_mult_pipe (
		.clock   (clock),
		.reset   (reset),
		.flush   (flush),
		.start   (mult_start),
		.func    (mult_func),
		.mcand   (rs1_value),
		.mplier  (rs2_value),
		.tag_in  (dest_tag),
		.done    (mult_done),
		.product (mult_product),
		.tag_out (mult_tag)
	);

	complete_queue #(
		.MULT_STAGES (MULT_STAGES),
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) u_complete_queue (
		.clock           (clock),
		.reset           (reset),
		.flush           (flush),
		.now_valid       (now_valid),
		.now_tag         (dest_tag),
		.now_result      (now_result),
		.now_take        (now_take),
		.now_target      (now_target),
		.mult_done       (mult_done),
		.mult_tag        (mult_tag),
		.mult_product    (mult_product),
		.issue_ready     (issue_ready),
		.complete_valid  (complete_valid),
		.complete_tag    (complete_tag),
		.complete_result (complete_result),
		.take_branch     (take_branch),
		.branch_target   (branch_target),
		.reg_wr_en       (reg_wr_en)
	);

endmodule

// ==== rtl/operand_select.sv ====
////////////////////////////////////////
// operand A and B muxes for the execute
// stage, with RV32 immediate decoding
// purely combinational
////////////////////////////////////////

`timescale 1ns/10ps

module operand_select (
	input  ex_pkg::opa_sel_t opa_sel,
	input  ex_pkg::opb_sel_t opb_sel,
	input  ex_pkg::inst_t    inst,
	input  ex_pkg::word_t    pc,
	input  ex_pkg::word_t    npc,
	input  ex_pkg::word_t    rs1_value,
	input  ex_pkg::word_t    rs2_value,
	output ex_pkg::word_t    opa,
	output ex_pkg::word_t    opb
);
	import ex_pkg::*;

	localparam word_t OPB_MARKER = 32'hfacefeed; // shows up on a bad opb_sel

	word_t i_imm, s_imm, b_imm, u_imm, j_imm;

	// sign-extended immediates, all keyed off bit 31
	assign i_imm = {{20{inst[31]}}, inst[31:20]};
	assign s_imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign b_imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign u_imm = {inst[31:12], 12'b0};
	assign j_imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		case (opa_sel)
			OPA_RS1: opa = rs1_value;
			OPA_NPC: opa = npc;
			OPA_PC:  opa = pc;
			default: opa = '0; // OPA_ZERO
		endcase
	end

	always_comb begin
		case (opb_sel)
			OPB_RS2:   opb = rs2_value;
			OPB_I_IMM: opb = i_imm;
			OPB_S_IMM: opb = s_imm;
			OPB_B_IMM: opb = b_imm;
			OPB_U_IMM: opb = u_imm;
			OPB_J_IMM: opb = j_imm;
			default:   opb = OPB_MARKER;
		endcase
	end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module tb_ex_stage -f all.f || exit 1
out=$(./obj_dir/Vtb_ex_stage)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qF '*** PASSED ***' && echo "simulation passed" || {
	echo "simulation failed"
	exit 1
}

// ==== sim/ex_model.svh ====
////////////////////////////////////////
// reference model of the execute stage
// operand, ALU, multiply and branch rules
// included inside the testbench module
////////////////////////////////////////

`ifndef EX_MODEL_SVH
`define EX_MODEL_SVH

function automatic word_t select_opa(opa_sel_t sel, word_t pc_v, word_t npc_v, word_t rs1);
	case (sel)
		OPA_RS1: return rs1;
		OPA_NPC: return npc_v;
		OPA_PC:  return pc_v;
		default: return '0;
	endcase
endfunction

// immediates rebuilt from the RV32 encoding tables
function automatic word_t select_opb(opb_sel_t sel, inst_t in, word_t rs2);
	logic signed [12:0] b13;
	logic signed [20:0] j21;
	b13 = {in[31], in[7], in[30:25], in[11:8], 1'b0};
	j21 = {in[31], in[19:12], in[20], in[30:21], 1'b0};
	case (sel)
		OPB_RS2:   return rs2;
		OPB_I_IMM: return word_t'($signed(in) >>> 20);
		OPB_S_IMM: return (word_t'($signed(in) >>> 20) & 32'hffffffe0) | {27'd0, in[11:7]};
		OPB_B_IMM: return word_t'(int'(b13));
		OPB_U_IMM: return in & 32'hfffff000;
		OPB_J_IMM: return word_t'(int'(j21));
		default:   return '0;
	endcase
endfunction

function automatic word_t alu_op(alu_func_t f, word_t a, word_t b);
	int sa;
	sa = int'(a);
	case (f)
		ALU_ADD:  return a + b;
		ALU_SUB:  return a + ~b + 32'd1;
		ALU_AND:  return a & b;
		ALU_OR:   return a | b;
		ALU_XOR:  return a ^ b;
		ALU_SLT:  return (sa < int'(b)) ? 32'd1 : 32'd0;
		ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
		ALU_SLL:  return a << b[4:0];
		ALU_SRL:  return a >> b[4:0];
		ALU_SRA:  return word_t'(sa >>> b[4:0]);
		default:  return '0;
	endcase
endfunction

// rs1 is signed for all but mulhu, rs2 only for mul and mulh
function automatic word_t multiply(mult_func_t f, word_t a, word_t b);
	longint p;
	case (f)
		MULT_MUL, MULT_MULH: p = longint'(int'(a)) * longint'(int'(b));
		MULT_MULHSU:         p = longint'(int'(a)) * longint'({32'd0, b});
		default:             p = longint'({32'd0, a} * {32'd0, b});
	endcase
	return (f == MULT_MUL) ? p[31:0] : p[63:32];
endfunction

function automatic logic branch_cond(logic [2:0] f3, word_t a, word_t b);
	case (f3)
		3'b000:  return a == b;
		3'b001:  return a != b;
		3'b100:  return int'(a) < int'(b);
		3'b101:  return !(int'(a) < int'(b));
		3'b110:  return a < b;
		3'b111:  return !(a < b);
		default: return 1'b0;
	endcase
endfunction

`endif

// ==== sim/tb_ex_stage.sv ====
////////////////////////////////////////
// testbench for the execute stage
// runs ALU, operand, multiply, branch,
// burst and flush sequences and checks
// each completion against the model
////////////////////////////////////////

`timescale 1ns/10ps

module tb_ex_stage;
	import ex_pkg::*;

	localparam int MULT_STAGES     = 4;
	localparam int QUEUE_DEPTH     = 8;
	localparam int N_ALU           = 40;
	localparam int N_SEL           = 24;
	localparam int N_MULT          = 56;
	localparam int N_BRANCH        = 40;
	localparam int N_BURST         = 60;
	localparam int N_FLUSH         = 12;
	localparam int N_TOTAL         = N_ALU + N_SEL + N_MULT + N_BRANCH + N_BURST + N_FLUSH;
	localparam int WATCHDOG_CYCLES = 200 * N_TOTAL + 500;

	`include "ex_model.svh"

	logic       clock = 1'b0;
	logic       reset, flush, issue_valid, cond_branch, uncond_branch;
	unit_t      unit;
	alu_func_t  alu_func;
	mult_func_t mult_func;
	opa_sel_t   opa_sel;
	opb_sel_t   opb_sel;
	inst_t      inst;
	word_t      pc, npc, rs1_value, rs2_value;
	tag_t       dest_tag;
	logic       issue_ready, complete_valid, take_branch, reg_wr_en;
	tag_t       complete_tag;
	word_t      complete_result, branch_target;

	////////////////////////////////////////
	// scoreboard, indexed by tag
	////////////////////////////////////////
	logic  pending     [64];
	logic  is_mult     [64];
	logic  has_target  [64];
	word_t exp_result  [64];
	logic  exp_take    [64];
	word_t exp_target  [64];
	time   accept_time [64];
	int    issue_seq   [64];
	word_t zero_result [$]; // zero-tag ops, in issue order
	int    n_pending = 0;
	int    n_issued = 0;
	int    n_completed = 0;
	int    n_flushed = 0;
	int    errors = 0;
	int    seq_count = 0;
	int    last_mult_seq = -1;
	logic  saw_not_ready = 1'b0;
	tag_t  tag_cursor = '0;

	word_t      corners  [3] = '{32'h80000000, 32'hffffffff, 32'h00000001};
	logic [2:0] br_codes [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

	ex_stage #(
		.MULT_STAGES (MULT_STAGES),
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) u_ex_stage (.*);

	always #4 clock = ~clock;

	task automatic check_word(input string name, input word_t got, input word_t exp);
		assert (got === exp) else begin
			errors++;
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		assert (got === exp) else begin
			errors++;
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_rule(input logic ok, input string what);
		assert (ok) else begin
			errors++;
			$display("%s", what);
		end
	endtask

	// next nonzero tag that is not in flight
	function automatic tag_t free_tag();
		tag_t t;
		t = tag_cursor;
		for (int i = 0; i < 64; i++) begin
			t = (t == tag_t'(63)) ? tag_t'(1) : t + tag_t'(1);
			if (!pending[t]) break;
		end
		tag_cursor = t;
		return t;
	endfunction

	////////////////////////////////////////
	// completion checks
	////////////////////////////////////////
	always @(negedge clock) begin
		tag_t t;
		int   lat;
		if (!reset) begin
			if (!issue_ready) saw_not_ready = 1'b1;
			if (!complete_valid) begin
				check_bit("take_branch", take_branch, 1'b0);
				check_bit("reg_wr_en", reg_wr_en, 1'b0);
			end
			if (complete_valid) begin
				t = complete_tag;
				n_completed++;
				if (t == ZERO_TAG) begin
					check_rule(zero_result.size() > 0,
						"completion with tag zero while no such op was in flight");
					if (zero_result.size() > 0) begin
						check_word("complete_result", complete_result, zero_result.pop_front());
						check_bit("take_branch", take_branch, 1'b0);
						check_bit("reg_wr_en", reg_wr_en, 1'b0); // no destination, no write
					end
				end else begin
					check_rule(pending[t],
						$sformatf("tag %0d completed while it was not in flight", t));
					if (pending[t]) begin
						check_word("complete_result", complete_result, exp_result[t]);
						check_bit("take_branch", take_branch, exp_take[t]);
						check_bit("reg_wr_en", reg_wr_en, 1'b1);
						if (has_target[t]) check_word("branch_target", branch_target, exp_target[t]);
						lat = int'(($time - accept_time[t] + 4) / 8);
						if (is_mult[t]) begin
							check_rule(lat >= MULT_STAGES + 1,
								$sformatf("multiply tag %0d completed after %0d cycles", t, lat));
							check_rule(issue_seq[t] > last_mult_seq,
								$sformatf("multiply tag %0d completed out of issue order", t));
							last_mult_seq = issue_seq[t];
						end
						pending[t] = 1'b0;
						n_pending--;
					end
				end
			end
		end
	end

	////////////////////////////////////////
	// issue side
	////////////////////////////////////////
	// called on a rising edge, returns on the accepting edge
	task automatic issue_op(input unit_t u, input alu_func_t af, input mult_func_t mf,
			input opa_sel_t as, input opb_sel_t bs, input inst_t in, input word_t r1,
			input word_t r2, input logic cb, input logic ub, input logic no_dest);
		tag_t  t;
		word_t pcv, a, b, res;
		logic  tk;
		pcv = $urandom & 32'hfffffffc;
		t   = no_dest ? ZERO_TAG : free_tag();
		a   = select_opa(as, pcv, pcv + 32'd4, r1);
		b   = select_opb(bs, in, r2);
		tk  = 1'b0;
		if (u == UNIT_MULT) begin
			res = multiply(mf, r1, r2);
		end else if (u == UNIT_BRANCH) begin
			res = '0;
			tk  = ub | (cb & branch_cond(in[14:12], r1, r2));
		end else if (ub) begin
			res = pcv + 32'd4; // link value
			tk  = 1'b1;
		end else begin
			res = alu_op(af, a, b);
		end
		issue_valid   <= 1'b1;
		unit          <= u;
		alu_func      <= af;
		mult_func     <= mf;
		opa_sel       <= as;
		opb_sel       <= bs;
		inst          <= in;
		pc            <= pcv;
		npc           <= pcv + 32'd4;
		rs1_value     <= r1;
		rs2_value     <= r2;
		dest_tag      <= t;
		cond_branch   <= cb;
		uncond_branch <= ub;
		@(negedge clock);
		while (!issue_ready) @(negedge clock);
		@(posedge clock);
		n_issued++;
		if (t == ZERO_TAG) begin
			zero_result.push_back(res);
		end else begin
			pending[t]     = 1'b1;
			is_mult[t]     = u == UNIT_MULT;
			has_target[t]  = (u == UNIT_BRANCH) || (u == UNIT_ALU && ub);
			exp_result[t]  = res;
			exp_take[t]    = tk;
			exp_target[t]  = a + b;
			accept_time[t] = $time;
			issue_seq[t]   = seq_count;
			seq_count++;
			n_pending++;
		end
	endtask

	task automatic stop_issue();
		issue_valid <= 1'b0;
	endtask

	task automatic wait_drain();
		while (n_pending != 0 || zero_result.size() != 0) @(negedge clock);
		@(posedge clock);
	endtask

	task automatic check_idle();
		check_bit("complete_valid", complete_valid, 1'b0);
		check_bit("reg_wr_en", reg_wr_en, 1'b0);
		check_bit("take_branch", take_branch, 1'b0);
		check_bit("issue_ready", issue_ready, 1'b1);
	endtask

	task automatic random_branch(input logic [2:0] code, input int k);
		inst_t in;
		word_t r1, r2;
		in = $urandom;
		in[14:12] = code;
		r1 = $urandom;
		case (k % 3)
			0:       r2 = r1;
			1:       r2 = $urandom;
			default: r2 = r1 ^ 32'h80000000; // signed and unsigned disagree
		endcase
		issue_op(UNIT_BRANCH, ALU_ADD, MULT_MUL, OPA_PC, OPB_B_IMM, in, r1, r2,
			1'b1, 1'b0, 1'b0);
	endtask

	task automatic run_alu_random();
		for (int k = 0; k < N_ALU; k++) begin
			issue_op(UNIT_ALU, alu_func_t'(k % 10), MULT_MUL, OPA_RS1, OPB_RS2, $urandom,
				$urandom, $urandom, 1'b0, 1'b0, 1'b0);
		end
		stop_issue();
		wait_drain();
	endtask

	task automatic run_operand_selects();
		for (int i = 0; i < 4; i++) begin
			for (int j = 0; j < 6; j++) begin
				issue_op(UNIT_ALU, ALU_ADD, MULT_MUL, opa_sel_t'(i), opb_sel_t'(j), $urandom,
					$urandom, $urandom, 1'b0, 1'b0, 1'b0);
			end
		end
		stop_issue();
		wait_drain();
	endtask

	task automatic run_multiplies();
		for (int f = 0; f < 4; f++) begin
			for (int i = 0; i < 3; i++) begin
				for (int j = 0; j < 3; j++) begin
					issue_op(UNIT_MULT, ALU_ADD, mult_func_t'(f), OPA_RS1, OPB_RS2, $urandom,
						corners[i], corners[j], 1'b0, 1'b0, 1'b0);
				end
			end
		end
		for (int k = 0; k < N_MULT - 36; k++) begin
			issue_op(UNIT_MULT, ALU_ADD, mult_func_t'($urandom_range(3, 0)), OPA_RS1, OPB_RS2,
				$urandom, $urandom, $urandom, 1'b0, 1'b0, 1'b0);
		end
		stop_issue();
		wait_drain();
	endtask

	task automatic run_branches();
		for (int c = 0; c < 6; c++) begin
			for (int k = 0; k < 6; k++) begin
				random_branch(br_codes[c], k);
			end
		end
		// jal and jalr style jumps through the ALU
		for (int k = 0; k < 4; k++) begin
			issue_op(UNIT_ALU, ALU_ADD, MULT_MUL, (k < 2) ? OPA_PC : OPA_RS1,
				(k < 2) ? OPB_J_IMM : OPB_I_IMM, $urandom, $urandom, $urandom,
				1'b0, 1'b1, 1'b0);
		end
		stop_issue();
		wait_drain();
	endtask

	task automatic run_burst();
		int kind;
		saw_not_ready = 1'b0;
		for (int k = 0; k < N_BURST; k++) begin
			kind = $urandom_range(3, 0);
			if (kind < 2) begin
				issue_op(UNIT_MULT, ALU_ADD, mult_func_t'($urandom_range(3, 0)), OPA_RS1,
					OPB_RS2, $urandom, $urandom, $urandom, 1'b0, 1'b0, 1'b0);
			end else if (kind == 2) begin
				issue_op(UNIT_ALU, alu_func_t'($urandom_range(9, 0)), MULT_MUL, OPA_RS1,
					OPB_RS2, $urandom, $urandom, $urandom, 1'b0, 1'b0,
					$urandom_range(3, 0) == 0);
			end else begin
				random_branch(br_codes[$urandom_range(5, 0)], k);
			end
		end
		stop_issue();
		wait_drain();
		check_rule(saw_not_ready, "issue_ready never fell while the burst filled the queue");
	endtask

	task automatic run_flush();
		for (int k = 0; k < 4; k++) begin
			issue_op(UNIT_MULT, ALU_ADD, mult_func_t'(k), OPA_RS1, OPB_RS2, $urandom,
				$urandom, $urandom, 1'b0, 1'b0, 1'b0);
		end
		for (int k = 0; k < 2; k++) begin
			issue_op(UNIT_ALU, ALU_XOR, MULT_MUL, OPA_RS1, OPB_RS2, $urandom,
				$urandom, $urandom, 1'b0, 1'b0, 1'b0);
		end
		// issue held up during the flush must be dropped too
		flush         <= 1'b1;
		unit          <= UNIT_ALU;
		uncond_branch <= 1'b0;
		dest_tag      <= free_tag();
		@(posedge clock);
		n_flushed = n_flushed + n_pending + zero_result.size();
		for (int i = 0; i < 64; i++) pending[i] = 1'b0;
		n_pending = 0;
		zero_result.delete();
		flush       <= 1'b0;
		issue_valid <= 1'b0;
		@(negedge clock);
		check_idle();
		repeat (MULT_STAGES + 10) @(posedge clock); // nothing may complete here
		for (int k = 0; k < N_FLUSH - 6; k++) begin
			issue_op((k % 2 == 0) ? UNIT_MULT : UNIT_ALU, ALU_SUB, MULT_MULHU, OPA_RS1,
				OPB_RS2, $urandom, $urandom, $urandom, 1'b0, 1'b0, 1'b0);
		end
		stop_issue();
		wait_drain();
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////
	initial begin
		void'($urandom(45002));
		reset         = 1'b1;
		flush         = 1'b0;
		issue_valid   = 1'b0;
		unit          = UNIT_ALU;
		alu_func      = ALU_ADD;
		mult_func     = MULT_MUL;
		opa_sel       = OPA_RS1;
		opb_sel       = OPB_RS2;
		inst          = '0;
		pc            = '0;
		npc           = '0;
		rs1_value     = '0;
		rs2_value     = '0;
		dest_tag      = ZERO_TAG;
		cond_branch   = 1'b0;
		uncond_branch = 1'b0;
		for (int i = 0; i < 64; i++) pending[i] = 1'b0;
		repeat (2) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		check_idle();
		repeat (10) @(posedge clock); // quiet after reset
		run_alu_random();
		run_operand_selects();
		run_multiplies();
		run_branches();
		run_burst();
		run_flush();
		repeat (5) @(posedge clock);
		check_rule(n_completed + n_flushed == n_issued,
			$sformatf("%0d ops issued but %0d completed and %0d flushed",
				n_issued, n_completed, n_flushed));
		$display("errors: %0d, issued: %0d, completed: %0d, flushed: %0d",
			errors, n_issued, n_completed, n_flushed);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("*** FAILED ***");
		$finish;
	end

endmodule
